// File: rtl/uart_cfg_pkg.sv
`default_nettype none

package uart_cfg_pkg;

	// frame layout
	localparam int DATA_W = 8;                 // data bits per frame, lsb first on the line

	// defaults for the module parameters, top level overrides them
	localparam int DEF_CLKS_PER_BIT = 8;       // clk cycles per serial bit
	localparam bit DEF_PARITY_EN    = 1'b1;    // parity slot present
	localparam bit DEF_PARITY_ODD   = 1'b0;    // 0 even, 1 odd
	localparam int DEF_SYNC_STAGES  = 3;       // rx synchronizer depth

	// start + data + optional parity + stop
	function automatic int frame_bits(input bit parity_en);
		int n_bits;
		n_bits = DATA_W + 2 + int'(parity_en);
		return n_bits;
	endfunction

endpackage

`default_nettype wire

// File: rtl/uart_frame_pkg.sv
`default_nettype none

package uart_frame_pkg;

	import uart_cfg_pkg::*;

	// field layout of a transmit frame, start sits at bit 0
	typedef struct packed {
		logic              stop;
		logic              parity;
		logic [DATA_W-1:0] data;
		logic              start;
	} tx_fields_t;

	// loaded through fields, shifted out through raw
	typedef union packed {
		tx_fields_t        fields;
		logic [DATA_W+2:0] raw;
	} tx_frame_u;

	// receive sequencing
	typedef enum logic [2:0] {
		st_idle,
		st_start,
		st_data,
		st_parity,
		st_stop
	} rx_state_e;

endpackage

`default_nettype wire

// File: rtl/uart_rx_if.sv
`timescale 1ns/1ns
`default_nettype none

interface uart_rx_if;

	logic rx_bit;        // synchronized line level
	logic start_edge;    // falling edge on the line
	logic shift_data;    // capture one data bit
	logic check_parity;  // fold the parity bit in
	logic clear;         // new frame, reset the accumulator
	logic commit;        // frame accepted, publish the data
	logic parity_bad;    // accumulated parity disagrees

	modport fsm (
		input  rx_bit,
		input  start_edge,
		input  parity_bad,
		output shift_data,
		output check_parity,
		output clear,
		output commit
	);

	modport dp (
		output rx_bit,
		output start_edge,
		output parity_bad,
		input  shift_data,
		input  check_parity,
		input  clear,
		input  commit
	);

endinterface

`default_nettype wire

// File: rtl/bit_timer.sv
`timescale 1ns/1ns
`default_nettype none

module bit_timer
	import uart_cfg_pkg::*;
#(
	parameter int CLKS_PER_BIT = DEF_CLKS_PER_BIT
) (
	input  wire  clk,
	input  wire  reset,
	input  wire  i_restart,
	output logic o_mid_tick,
	output logic o_end_tick
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] MID_CNT  = CNT_W'(CLKS_PER_BIT / 2 - 1);
	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS_PER_BIT - 1);

	logic [CNT_W-1:0] cnt;

	// modulo counter, restart lines the period up with a frame
	always_ff @(posedge clk) begin
		if (reset || i_restart) begin
			cnt <= '0;
		end else if (cnt == LAST_CNT) begin
			cnt <= '0;  // free run after the first period
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	assign o_mid_tick = (cnt == MID_CNT);   // half a period in
	assign o_end_tick = (cnt == LAST_CNT);  // last cycle of the bit

endmodule

`default_nettype wire

// File: rtl/uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx
	import uart_cfg_pkg::*;
	import uart_frame_pkg::*;
#(
	parameter bit PARITY_EN  = DEF_PARITY_EN,
	parameter bit PARITY_ODD = DEF_PARITY_ODD
) (
	input  wire              clk,
	input  wire              reset,
	input  wire              i_enable,
	input  wire [DATA_W-1:0] i_data,
	input  wire              i_end_tick,
	output logic             o_restart,
	output logic             o_busy,
	output logic             o_serial
);

	localparam int CNT_W = $clog2(DATA_W + 3);
	localparam logic [CNT_W-1:0] LAST_BIT  = CNT_W'(frame_bits(PARITY_EN) - 1);
	localparam logic [CNT_W-1:0] LAST_DATA = CNT_W'(DATA_W);  // start occupies slot 0

	tx_frame_u        frame;
	logic [CNT_W-1:0] bit_cnt;  // bits already on the line
	logic             busy;
	logic             accept;
	logic             bit_done;

	assign accept    = i_enable & ~busy;  // enable while busy is dropped
	assign bit_done  = busy & i_end_tick;
	assign o_restart = accept;            // timer period starts with the start bit
	assign o_busy    = busy;
	assign o_serial  = ~busy | frame.raw[0];  // idle line is high

	always_ff @(posedge clk) begin
		if (reset) begin
			busy    <= 1'b0;
			bit_cnt <= '0;
		end else if (accept) begin
			busy    <= 1'b1;
			bit_cnt <= '0;
		end else if (bit_done) begin
			if (bit_cnt == LAST_BIT) begin
				busy <= 1'b0;  // stop bit has run its full period
			end
			bit_cnt <= bit_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			frame.fields.start  <= 1'b0;
			frame.fields.data   <= i_data;
			frame.fields.parity <= (^i_data) ^ PARITY_ODD;
			frame.fields.stop   <= 1'b1;
		end else if (bit_done) begin
			if (!PARITY_EN && bit_cnt == LAST_DATA) begin
				frame.raw <= frame.raw >> 2;  // hop over the parity slot
			end else begin
				frame.raw <= frame.raw >> 1;
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/uart_rx_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx_fsm
	import uart_cfg_pkg::*;
	import uart_frame_pkg::*;
#(
	parameter bit PARITY_EN = DEF_PARITY_EN
) (
	input  wire      clk,
	input  wire      reset,
	uart_rx_if.fsm   rx,
	input  wire      i_mid_tick,
	output logic     o_restart,
	output logic     o_valid,
	output logic     o_error
);

	localparam int CNT_W = $clog2(DATA_W);
	localparam logic [CNT_W-1:0] LAST_DATA = CNT_W'(DATA_W - 1);

	rx_state_e        state;
	logic [CNT_W-1:0] bit_cnt;
	logic             stop_sample;
	logic             frame_ok;

	assign o_restart       = (state == st_idle) && rx.start_edge;  // sample point from the edge
	assign rx.clear        = o_restart;
	assign rx.shift_data   = (state == st_data) && i_mid_tick;
	assign rx.check_parity = (state == st_parity) && i_mid_tick;

	// stop must read high, parity only counts when the slot exists
	assign stop_sample = (state == st_stop) && i_mid_tick;
	assign frame_ok    = rx.rx_bit && !(PARITY_EN && rx.parity_bad);
	assign rx.commit   = stop_sample && frame_ok;

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= st_idle;
			bit_cnt <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (rx.start_edge) begin
						state <= st_start;
					end
				end
				st_start: begin
					if (i_mid_tick) begin
						bit_cnt <= '0;
						// line back high by mid start, treat as a glitch
						state   <= rx.rx_bit ? st_idle : st_data;
					end
				end
				st_data: begin
					if (i_mid_tick) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == LAST_DATA) begin
							state <= PARITY_EN ? st_parity : st_stop;
						end
					end
				end
				st_parity: begin
					if (i_mid_tick) begin
						state <= st_stop;
					end
				end
				st_stop: begin
					if (i_mid_tick) begin
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// registered so o_data is already updated when valid shows
	always_ff @(posedge clk) begin
		if (reset) begin
			o_valid <= 1'b0;
			o_error <= 1'b0;
		end else begin
			o_valid <= rx.commit;
			o_error <= stop_sample && !frame_ok;
		end
	end

endmodule

`default_nettype wire

// File: rtl/uart_rx_datapath.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx_datapath
	import uart_cfg_pkg::*;
#(
	parameter int SYNC_STAGES = DEF_SYNC_STAGES,
	parameter bit PARITY_ODD  = DEF_PARITY_ODD
) (
	input  wire               clk,
	input  wire               reset,
	input  wire               i_serial,
	uart_rx_if.dp             rx,
	output logic [DATA_W-1:0] o_data
);

	logic [SYNC_STAGES-1:0] sync;        // async line into clk domain
	logic                   line;
	logic                   prev_line;
	logic [DATA_W-1:0]      shift_reg;   // staging, lsb arrives first
	logic                   parity_acc;  // xor of data and parity bits

	assign line          = sync[SYNC_STAGES-1];
	assign rx.rx_bit     = line;
	assign rx.start_edge = prev_line & ~line;
	assign rx.parity_bad = parity_acc ^ PARITY_ODD;  // even wants 0, odd wants 1

	always_ff @(posedge clk) begin
		if (reset) begin
			sync      <= '1;  // idle high, no false edge out of reset
			prev_line <= 1'b1;
		end else begin
			sync      <= {sync[SYNC_STAGES-2:0], i_serial};
			prev_line <= line;
		end
	end

	always_ff @(posedge clk) begin
		if (reset || rx.clear) begin
			parity_acc <= 1'b0;
		end else if (rx.shift_data || rx.check_parity) begin
			parity_acc <= parity_acc ^ line;
		end
	end

	always_ff @(posedge clk) begin
		if (rx.shift_data) begin
			shift_reg <= {line, shift_reg[DATA_W-1:1]};  // shift right
		end
	end

	// bad frames never reach the output
	always_ff @(posedge clk) begin
		if (reset) begin
			o_data <= '0;
		end else if (rx.commit) begin
			o_data <= shift_reg;
		end
	end

endmodule

`default_nettype wire

// File: rtl/uart_loop_top.sv
`timescale 1ns/1ns
`default_nettype none

module uart_loop_top
	import uart_cfg_pkg::*;
#(
	parameter int CLKS_PER_BIT = DEF_CLKS_PER_BIT,
	parameter bit PARITY_EN    = DEF_PARITY_EN,
	parameter bit PARITY_ODD   = DEF_PARITY_ODD,
	parameter int SYNC_STAGES  = DEF_SYNC_STAGES
) (
	input  wire               clk,
	input  wire               reset,
	input  wire               i_tx_enable,
	input  wire  [DATA_W-1:0] i_tx_data,
	output logic              o_tx_busy,
	output logic              o_serial,
	input  wire               i_serial,
	output logic [DATA_W-1:0] o_rx_data,
	output logic              o_rx_valid,
	output logic              o_rx_error
);

	logic tx_restart;
	logic tx_end_tick;
	logic rx_restart;
	logic rx_mid_tick;

	uart_rx_if rx_if ();

	// tx side only needs bit boundaries
	bit_timer #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) tx_timer (
		.clk        (clk),
		.reset      (reset),
		.i_restart  (tx_restart),
		.o_mid_tick (),
		.o_end_tick (tx_end_tick)
	);

	uart_tx #(
		.PARITY_EN  (PARITY_EN),
		.PARITY_ODD (PARITY_ODD)
	) tx (
		.clk        (clk),
		.reset      (reset),
		.i_enable   (i_tx_enable),
		.i_data     (i_tx_data),
		.i_end_tick (tx_end_tick),
		.o_restart  (tx_restart),
		.o_busy     (o_tx_busy),
		.o_serial   (o_serial)
	);

	// rx side samples at mid bit
	bit_timer #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) rx_timer (
		.clk        (clk),
		.reset      (reset),
		.i_restart  (rx_restart),
		.o_mid_tick (rx_mid_tick),
		.o_end_tick ()
	);

	uart_rx_fsm #(
		.PARITY_EN (PARITY_EN)
	) rx_fsm (
		.clk        (clk),
		.reset      (reset),
		.rx         (rx_if.fsm),
		.i_mid_tick (rx_mid_tick),
		.o_restart  (rx_restart),
		.o_valid    (o_rx_valid),
		.o_error    (o_rx_error)
	);

	uart_rx_datapath #(
		.SYNC_STAGES (SYNC_STAGES),
		.PARITY_ODD  (PARITY_ODD)
	) rx_dp (
		.clk      (clk),
		.reset    (reset),
		.i_serial (i_serial),
		.rx       (rx_if.dp),
		.o_data   (o_rx_data)
	);

endmodule

`default_nettype wire

// File: bench/clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module clk_gen #(
	parameter int HALF_PERIOD  = 2,
	parameter int RESET_CYCLES = 4
) (
	output logic o_clk,
	output logic o_reset
);

	initial begin
		o_clk = 1'b0;
		forever #HALF_PERIOD o_clk = ~o_clk;
	end

	initial begin
		o_reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge o_clk);
		#1 o_reset = 1'b0;  // released off the edge like other inputs
	end

endmodule

`default_nettype wire

// File: bench/uart_props.sv
`timescale 1ns/1ns
`default_nettype none

module uart_props (
	input wire clk,
	input wire reset,
	input wire i_rx_valid,
	input wire i_rx_error
);

	int fail_cnt = 0;  // read by the testbench at the end

	a_valid_xor_error: assert property (@(posedge clk) disable iff (reset)
		!(i_rx_valid && i_rx_error))
		else begin
			fail_cnt = fail_cnt + 1;
			$error("rx valid and rx error high in the same cycle");
		end

	a_valid_pulse: assert property (@(posedge clk) disable iff (reset)
		i_rx_valid |=> !i_rx_valid)
		else begin
			fail_cnt = fail_cnt + 1;
			$error("rx valid held longer than one cycle");
		end

	a_error_pulse: assert property (@(posedge clk) disable iff (reset)
		i_rx_error |=> !i_rx_error)
		else begin
			fail_cnt = fail_cnt + 1;
			$error("rx error held longer than one cycle");
		end

endmodule

bind uart_loop_top uart_props props_i (
	.clk        (clk),
	.reset      (reset),
	.i_rx_valid (o_rx_valid),
	.i_rx_error (o_rx_error)
);

`default_nettype wire

// File: bench/uart_tb.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tb
	import uart_cfg_pkg::*;
;

	localparam int CLKS_PER_BIT = DEF_CLKS_PER_BIT;
	localparam bit PARITY_EN    = DEF_PARITY_EN;
	localparam bit PARITY_ODD   = DEF_PARITY_ODD;
	localparam int SYNC_STAGES  = DEF_SYNC_STAGES;
	localparam int FRAME_BITS   = DATA_W + 2 + (PARITY_EN ? 1 : 0);
	localparam int FRAME_CLKS   = FRAME_BITS * CLKS_PER_BIT;
	localparam int N_BYTES      = 30;
	localparam int LIMIT        = 40 * FRAME_CLKS + 200;

	logic              clk;
	logic              reset;
	logic              i_tx_enable;
	logic [DATA_W-1:0] i_tx_data;
	logic              o_tx_busy;
	logic              o_serial;
	logic              serial_line;
	logic [DATA_W-1:0] o_rx_data;
	logic              o_rx_valid;
	logic              o_rx_error;

	logic                  loopback;     // 0 hands the line to the injector
	logic                  inj_line;
	logic                  started;
	logic [DATA_W-1:0]     held_data;
	logic [DATA_W-1:0]     sent [64];
	logic                  m_busy;       // reference line model
	logic [FRAME_BITS-1:0] m_frame;
	int                    m_sub;
	int                    m_left;
	logic                  exp_serial;
	int                    acc_cnt;
	int                    valid_cnt;
	int                    rx_err_cnt;
	int                    busy_len = 0;
	int                    cycles = 0;
	int                    fail_count;

	clk_gen clk_gen_i (.o_clk(clk), .o_reset(reset));

	assign serial_line = loopback ? o_serial : inj_line;
	assign exp_serial  = m_busy ? m_frame[0] : 1'b1;

	uart_loop_top #(
		.CLKS_PER_BIT (CLKS_PER_BIT),
		.PARITY_EN    (PARITY_EN),
		.PARITY_ODD   (PARITY_ODD),
		.SYNC_STAGES  (SYNC_STAGES)
	) uart_loop_top_i (
		.clk         (clk),
		.reset       (reset),
		.i_tx_enable (i_tx_enable),
		.i_tx_data   (i_tx_data),
		.o_tx_busy   (o_tx_busy),
		.o_serial    (o_serial),
		.i_serial    (serial_line),
		.o_rx_data   (o_rx_data),
		.o_rx_valid  (o_rx_valid),
		.o_rx_error  (o_rx_error)
	);

	// start 0, data lsb first, parity, stop 1
	function automatic logic [FRAME_BITS-1:0] line_frame(input logic [DATA_W-1:0] d,
			input logic bad_par, input logic bad_stop);
		logic [FRAME_BITS-1:0] f;
		f = '0;
		f[DATA_W:1] = d;
		if (PARITY_EN) begin
			f[DATA_W+1] = (^d) ^ PARITY_ODD ^ bad_par;
		end
		f[FRAME_BITS-1] = ~bad_stop;
		return f;
	endfunction

	always @(posedge clk) begin
		if (reset) begin
			m_busy <= 1'b0;
			acc_cnt <= 0;
		end else if (i_tx_enable && !m_busy) begin
			m_busy  <= 1'b1;
			m_frame <= line_frame(i_tx_data, 1'b0, 1'b0);
			m_sub   <= 0;
			m_left  <= FRAME_BITS;
			sent[acc_cnt[5:0]] <= i_tx_data;
			acc_cnt <= acc_cnt + 1;
		end else if (m_busy) begin
			if (m_sub == CLKS_PER_BIT - 1) begin
				m_sub   <= 0;
				m_frame <= m_frame >> 1;
				m_left  <= m_left - 1;
				if (m_left == 1) begin
					m_busy <= 1'b0;
				end
			end else begin
				m_sub <= m_sub + 1;
			end
		end
	end

	always @(posedge clk) begin
		if (reset) begin
			valid_cnt  <= 0;
			rx_err_cnt <= 0;
		end else begin
			if (o_rx_valid) begin
				valid_cnt <= valid_cnt + 1;
			end
			if (o_rx_error) begin
				rx_err_cnt <= rx_err_cnt + 1;
			end
		end
		busy_len <= o_tx_busy ? busy_len + 1 : 0;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", LIMIT);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	a_idle: assert property (@(posedge clk) disable iff (reset)
		!started |-> o_serial && !o_tx_busy && !o_rx_valid && !o_rx_error)
		else begin
			fail_count = fail_count + 1;
			$display("Mismatch at %0t: outputs left idle before the first enable", $time);
		end

	a_accept: assert property (@(posedge clk) disable iff (reset)
		i_tx_enable && !o_tx_busy |=> o_tx_busy)
		else begin
			fail_count = fail_count + 1;
			$display("Mismatch at %0t: busy did not rise after an accepted enable", $time);
		end

	a_busy_len: assert property (@(posedge clk) disable iff (reset)
		$fell(o_tx_busy) |-> busy_len == FRAME_CLKS)
		else begin
			fail_count = fail_count + 1;
			$display("Mismatch at %0t: busy lasted %0d cycles, expected %0d",
				$time, $sampled(busy_len), FRAME_CLKS);
		end

	a_line: assert property (@(posedge clk) disable iff (reset) o_serial == exp_serial)
		else begin
			fail_count = fail_count + 1;
			$display("Mismatch at %0t: serial line %b, expected %b",
				$time, $sampled(o_serial), $sampled(exp_serial));
		end

	a_rx_data: assert property (@(posedge clk) disable iff (reset)
		o_rx_valid |-> o_rx_data == sent[valid_cnt[5:0]] && !o_rx_error)
		else begin
			fail_count = fail_count + 1;
			$display("Mismatch at %0t: received %h, expected %h", $time,
				$sampled(o_rx_data), $sampled(sent[valid_cnt[5:0]]));
		end

	a_loop_no_error: assert property (@(posedge clk) disable iff (reset)
		loopback |-> !o_rx_error)
		else begin
			fail_count = fail_count + 1;
			$display("Mismatch at %0t: rx error on a clean loopback frame", $time);
		end

	a_inject: assert property (@(posedge clk) disable iff (reset)
		!loopback |-> !o_rx_valid && o_rx_data == held_data)
		else begin
			fail_count = fail_count + 1;
			$display("Mismatch at %0t: bad frame reached the rx data, %h held %h",
				$time, $sampled(o_rx_data), $sampled(held_data));
		end

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	// optional second enable lands mid frame and must be dropped
	task automatic send_byte(input bit extra_enable);
		logic [31:0] r;
		r = $urandom();
		started = 1'b1;
		while (o_tx_busy) next_cycle();
		i_tx_enable = 1'b1;
		i_tx_data   = r[DATA_W-1:0];
		next_cycle();
		i_tx_enable = 1'b0;
		if (extra_enable) begin
			repeat (3 * CLKS_PER_BIT) next_cycle();
			i_tx_enable = 1'b1;
			i_tx_data   = ~i_tx_data;
			next_cycle();
			i_tx_enable = 1'b0;
		end
		while (valid_cnt != acc_cnt) next_cycle();
	endtask

	task automatic inject_frame(input logic bad_par, input logic bad_stop);
		logic [31:0]           r;
		logic [FRAME_BITS-1:0] f;
		int                    want;
		r    = $urandom();
		f    = line_frame(r[DATA_W-1:0], bad_par, bad_stop);
		want = rx_err_cnt + 1;
		repeat (FRAME_BITS) begin
			inj_line = f[0];
			f = f >> 1;
			repeat (CLKS_PER_BIT) next_cycle();
		end
		inj_line = 1'b1;
		while (rx_err_cnt < want) next_cycle();
	endtask

	initial begin
		i_tx_enable = 1'b0;
		i_tx_data   = '0;
		inj_line    = 1'b1;
		loopback    = 1'b1;
		started     = 1'b0;
		held_data   = '0;
		fail_count  = 0;
		void'($urandom(14));
		wait (reset === 1'b0);
		repeat (20) next_cycle();
		for (int n = 0; n < N_BYTES; n++) begin
			send_byte(n % 3 == 1);
		end
		held_data = o_rx_data;
		loopback  = 1'b0;
		inject_frame(1'b1, 1'b0);
		inject_frame(1'b0, 1'b1);
		loopback = 1'b1;
		repeat (2 * CLKS_PER_BIT) next_cycle();
		assert (acc_cnt == N_BYTES && valid_cnt == acc_cnt && rx_err_cnt == 2)
			else begin
				fail_count = fail_count + 1;
				$display("Mismatch at %0t: %0d accepted, %0d valid, %0d rx errors",
					$time, acc_cnt, valid_cnt, rx_err_cnt);
			end
		$display("uart_tb: %0d sent, %0d received, %0d rx errors, %0d tb fails, %0d prop fails",
			acc_cnt, valid_cnt, rx_err_cnt, fail_count, uart_loop_top_i.props_i.fail_cnt);
		if (fail_count == 0 && uart_loop_top_i.props_i.fail_cnt == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
rtl/uart_cfg_pkg.sv
rtl/uart_frame_pkg.sv
rtl/uart_rx_if.sv
rtl/bit_timer.sv
rtl/uart_tx.sv
rtl/uart_rx_fsm.sv
rtl/uart_rx_datapath.sv
rtl/uart_loop_top.sv
bench/clk_gen.sv
bench/uart_props.sv
bench/uart_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     := --timing --assert
TOP       := uart_tb
RTL_TOP   := uart_loop_top
FILELIST  := sources.f
LOG       := sim.log
PASS_MSG  := STATUS: PASS
FAIL_MSG  := STATUS: FAIL
SIM_BIN   := obj_dir/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(SIM_BIN): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o V$(TOP)

sim: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@! grep -q "$(FAIL_MSG)" $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
